/* sim/tg_trace.txt */
# seq_count rand_count rand_seq_count block_size ready_duty corrupt_index
# ready high when an 8-bit random value <= ready_duty; corrupt_index -1 means none
2 0 0 4 255 -1
1 2 1 8 160 -1
0 0 0 5 200 -1
2 1 2 6 128 7
0 3 0 20 220 -1
0 0 2 12 90 15
3 0 0 3 255 2
1 1 1 1 180 -1
0 0 0 0 255 -1
1 1 1 16 240 40
0 0 3 5 64 0
2 2 2 7 200 -1
1 0 1 18 150 20
0 1 1 9 110 -1
4 0 0 2 230 5
1 1 0 10 75 -1
0 2 2 4 255 9

/* compile.f */
rtl/tg_cfg_pkg.sv
rtl/tg_mem_pkg.sv
rtl/tg_block_rw_stage.sv
rtl/tg_addr_gen.sv
rtl/tg_cmd_issue.sv
rtl/tg_read_compare.sv
rtl/tg_top.sv
sim/tg_tb.sv

/* Bender.yml */
package:
  name: tg_traffic_gen

sources:
  # Packages come before the modules that use them
  - rtl/tg_cfg_pkg.sv
  - rtl/tg_mem_pkg.sv
  - rtl/tg_block_rw_stage.sv
  - rtl/tg_addr_gen.sv
  - rtl/tg_cmd_issue.sv
  - rtl/tg_read_compare.sv
  - rtl/tg_top.sv

  - target: simulation
    files:
      - sim/tg_tb.sv

# Top modules: tg_top for synthesis, tg_tb for simulation
# Simulation reads sim/tg_trace.txt from the project root

/* sim/tg_tb.sv */
//////////////////////////////////////////////////
// Testbench for the memory traffic generator
// Runs every test of the trace file against a
// memory model with random ready and read latency
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tg_tb;

   // Read waiting in the memory model
   typedef struct packed {
      logic [15:0] addr;
      logic [31:0] due;
      logic        flip;
   } pend_t;

   logic                   clk;
   logic                   reset_n;
   tg_cfg_pkg::tg_cfg_t    cfg;
   logic                   stage_enable;
   logic                   mem_ready;
   tg_mem_pkg::mem_rsp_t   rsp;
   tg_mem_pkg::mem_cmd_t   cmd;
   tg_cfg_pkg::tg_status_t status;

   // Tests read from the trace
   tg_cfg_pkg::tg_cfg_t          cfg_q[$];
   int                           duty_q[$];
   int                           corrupt_q[$];

   // Running test and model state
   tg_cfg_pkg::tg_cfg_t          cur_cfg;
   int                           cur_duty;
   int                           cur_corrupt;
   int                           cur_ops;
   bit                           test_active;
   int                           writes_seen;
   int                           reads_seen;
   int                           rsps_given;
   int                           completes;
   int                           failures;
   int                           cycle;
   int                           limit_cycles;
   logic [15:0]                  corrupt_addr;
   logic [15:0]                  seq_next;
   logic [31:0]                  rng;
   tg_cfg_pkg::addr_gen_select_t last_gen;
   tg_mem_pkg::mem_addr_u        rs_base;
   tg_mem_pkg::mem_addr_u        block_q[$];
   pend_t                        pending[$];
   logic [31:0]                  mem_store [logic [15:0]];

   tg_top DUT (
      .clk          (clk),
      .reset_n      (reset_n),
      .cfg          (cfg),
      .stage_enable (stage_enable),
      .mem_ready    (mem_ready),
      .rsp          (rsp),
      .cmd          (cmd),
      .status       (status)
   );

   // 40 ns clock
   always #20 clk = ~clk;

   //////////////////////////////////////////////////
   // Random numbers and helpers
   //////////////////////////////////////////////////
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   // One LFSR step per bit taken
   function automatic int take_bits(input int n);
      int v;
      int i;
      v = 0;
      for (i = 0; i < n; i++) begin
         v   = (v << 1) | int'(rng[0]);
         rng = lfsr_next(rng);
      end
      return v;
   endfunction

   // Blocks run SEQ first, then RAND, then RAND_SEQ
   function automatic tg_cfg_pkg::addr_gen_select_t gen_for_block(input int b);
      int seq_end;
      int rand_end;
      seq_end  = int'(cur_cfg.seq_count);
      rand_end = seq_end + int'(cur_cfg.rand_count);
      if (b < seq_end)
         return tg_cfg_pkg::SEQ;
      if (b < rand_end)
         return tg_cfg_pkg::RAND;
      return tg_cfg_pkg::RAND_SEQ;
   endfunction

   task automatic stop_with_failure(input string msg);
      failures++;
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_cmd(input tg_mem_pkg::mem_cmd_t got, input tg_mem_pkg::mem_cmd_t exp,
                            input string what);
      if (got !== exp)
         stop_with_failure($sformatf("CHECK FAILED at %0t: %s cmd %h, expected %h",
                                     $time, what, got, exp));
   endtask

   task automatic check_status(input tg_cfg_pkg::tg_status_t got,
                               input tg_cfg_pkg::tg_status_t exp, input string what);
      if (got !== exp)
         stop_with_failure($sformatf("CHECK FAILED at %0t: %s %h, expected %h",
                                     $time, what, got, exp));
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp)
         stop_with_failure($sformatf("CHECK FAILED at %0t: %s %0d, expected %0d",
                                     $time, what, got, exp));
   endtask

   //////////////////////////////////////////////////
   // Command checks
   //////////////////////////////////////////////////
   task automatic handle_write(input tg_mem_pkg::mem_cmd_t c);
      tg_mem_pkg::mem_cmd_t         exp;
      tg_cfg_pkg::addr_gen_select_t gen;
      int                           blk;
      int                           idx;
      if (writes_seen >= cur_ops)
         stop_with_failure($sformatf("More writes than configured at %0t", $time));
      blk = writes_seen / int'(cur_cfg.block_size);
      idx = writes_seen % int'(cur_cfg.block_size);
      gen = gen_for_block(blk);
      if (idx == 0) begin
         if (reads_seen != writes_seen)
            stop_with_failure($sformatf("Block write at %0t before previous reads", $time));
         // Old generator's reads must all be back
         if (blk > 0 && gen != last_gen && pending.size() != 0)
            stop_with_failure($sformatf("Generator change at %0t with %0d reads outstanding",
                                        $time, pending.size()));
         block_q.delete();
         rs_base  = c.addr;
         last_gen = gen;
      end
      exp       = '0;
      exp.write = 1'b1;
      exp.addr  = c.addr;
      if (gen == tg_cfg_pkg::SEQ) begin
         exp.addr.flat = seq_next;
         seq_next++;
      end else if (gen == tg_cfg_pkg::RAND_SEQ) begin
         // Fixed bank and row, col counts from 0
         exp.addr.f.bank = rs_base.f.bank;
         exp.addr.f.row  = rs_base.f.row;
         exp.addr.f.col  = tg_mem_pkg::COL_W'(idx);
      end
      exp.wdata = {exp.addr.flat, exp.addr.flat ^ 16'hA5C3};
      check_cmd(c, exp, "write");
      mem_store[c.addr.flat] = c.wdata;
      block_q.push_back(c.addr);
      writes_seen++;
   endtask

   task automatic handle_read(input tg_mem_pkg::mem_cmd_t c);
      tg_mem_pkg::mem_cmd_t exp;
      pend_t                p;
      int                   idx;
      if (block_q.size() != int'(cur_cfg.block_size) || reads_seen >= writes_seen)
         stop_with_failure($sformatf("Read at %0t before its block was written", $time));
      idx      = reads_seen % int'(cur_cfg.block_size);
      exp      = '0;
      exp.read = 1'b1;
      exp.addr = block_q[idx];
      check_cmd(c, exp, "read");
      p.addr = c.addr.flat;
      p.due  = cycle + 1 + take_bits(2);
      p.flip = (reads_seen == cur_corrupt);
      if (p.flip)
         corrupt_addr = c.addr.flat;
      pending.push_back(p);
      reads_seen++;
   endtask

   task automatic end_of_test;
      tg_cfg_pkg::tg_status_t exp;
      check_count(writes_seen, cur_ops, "write count");
      check_count(reads_seen, cur_ops, "read count");
      check_count(rsps_given, cur_ops, "read responses before complete");
      exp          = '0;
      exp.complete = 1'b1;
      if (cur_corrupt >= 0) begin
         exp.error_count      = 16'd1;
         exp.first_error_addr = corrupt_addr;
         exp.mismatch_seen    = 1'b1;
      end
      check_status(status, exp, "status at complete");
      test_active = 1'b0;
      completes++;
   endtask

   //////////////////////////////////////////////////
   // Memory model, runs on the falling edge
   //////////////////////////////////////////////////
   always @(negedge clk) begin : memory_model
      pend_t                head;
      tg_mem_pkg::mem_rsp_t r;
      r = '0;
      if (reset_n) begin
         if (status.complete === 1'b1) begin
            if (!test_active)
               stop_with_failure("status.complete pulsed outside a running test");
            end_of_test();
         end
         if (cmd.write === 1'b1 || cmd.read === 1'b1) begin
            if (!test_active)
               stop_with_failure("Command issued outside a running test");
            // mem_ready still holds the level seen at that edge
            if (!mem_ready)
               stop_with_failure($sformatf("Command at %0t after mem_ready was low", $time));
            if (cmd.write)
               handle_write(cmd);
            else
               handle_read(cmd);
         end
         // In-order answer once the head is due
         if (pending.size() != 0 && pending[0].due <= cycle) begin
            head    = pending.pop_front();
            r.valid = 1'b1;
            r.rdata = mem_store[head.addr] ^ {31'd0, head.flip};
            rsps_given++;
         end
      end
      rsp       <= r;
      mem_ready <= (take_bits(8) <= cur_duty);
      cycle++;
   end

   // Limit comes from the trace
   initial begin : watchdog
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      stop_with_failure($sformatf("Timeout after %0d cycles, a test never completed",
                                  limit_cycles));
   end

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////
   initial begin : main
      int    fd;
      int    n;
      int    t;
      int    total;
      int    v[6];
      string line;
      tg_cfg_pkg::tg_cfg_t c;
      clk          = 1'b0;
      reset_n      = 1'b0;
      cfg          = '0;
      stage_enable = 1'b0;
      mem_ready    = 1'b0;
      rsp          = '0;
      rng          = 32'h9432;
      seq_next     = '0;
      cur_cfg      = '0;
      cur_duty     = 0;
      cur_corrupt  = -1;
      test_active  = 1'b0;
      total        = 0;
      fd = $fopen("sim/tg_trace.txt", "r");
      if (fd == 0)
         stop_with_failure("Could not open the trace file sim/tg_trace.txt");
      while (!$feof(fd)) begin
         line = "";
         n    = $fgets(line, fd);
         // Comment lines scan no fields
         if (n > 0 && $sscanf(line, "%d %d %d %d %d %d",
                              v[0], v[1], v[2], v[3], v[4], v[5]) == 6) begin
            c.seq_count      = 8'(v[0]);
            c.rand_count     = 8'(v[1]);
            c.rand_seq_count = 8'(v[2]);
            c.block_size     = 8'(v[3]);
            cfg_q.push_back(c);
            duty_q.push_back(v[4]);
            corrupt_q.push_back(v[5]);
            total += 2 * v[3] * (v[0] + v[1] + v[2]) * 20;
         end
      end
      $fclose(fd);
      if (cfg_q.size() == 0)
         stop_with_failure("The trace file holds no tests");
      limit_cycles = total + 1000;
      repeat (5) @(negedge clk);
      reset_n <= 1'b1;
      for (t = 0; t < cfg_q.size(); t++) begin
         // Load the test between edges of the model
         @(posedge clk);
         cur_cfg     = cfg_q[t];
         cur_duty    = duty_q[t];
         cur_corrupt = corrupt_q[t];
         cur_ops     = int'(cur_cfg.block_size) * (int'(cur_cfg.seq_count) +
                       int'(cur_cfg.rand_count) + int'(cur_cfg.rand_seq_count));
         writes_seen  = 0;
         reads_seen   = 0;
         rsps_given   = 0;
         corrupt_addr = '0;
         block_q.delete();
         test_active  = 1'b1;
         @(negedge clk);
         cfg          <= cfg_q[t];
         stage_enable <= 1'b1;
         @(negedge clk);
         stage_enable <= 1'b0;
         wait (completes == t + 1);
      end
      @(negedge clk);
      if (failures == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/tg_top.sv */
//////////////////////////////////////////////////
// Top of the memory traffic generator
// Pulse stage_enable while idle to start a test;
// status.complete marks its end
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tg_top (
   input  logic                   clk,
   input  logic                   reset_n,
   input  tg_cfg_pkg::tg_cfg_t    cfg,
   input  logic                   stage_enable,
   input  logic                   mem_ready,
   input  tg_mem_pkg::mem_rsp_t   rsp,
   output tg_mem_pkg::mem_cmd_t   cmd,
   output tg_cfg_pkg::tg_status_t status
);

   logic                         can_write;
   logic                         can_read;
   logic                         fifo_full;
   logic                         fifo_empty;
   logic                         do_write;
   logic                         do_read;
   logic                         block_start;
   logic                         read_start;
   logic                         stage_complete;
   tg_cfg_pkg::addr_gen_select_t addr_gen_select;
   tg_mem_pkg::mem_addr_u        addr;
   tg_mem_pkg::mem_addr_u        first_error_addr;
   logic [15:0]                  error_count;
   logic                         mismatch_seen;

   // Reads also need room for their expected address
   assign can_write = mem_ready;
   assign can_read  = mem_ready && !fifo_full;

   tg_block_rw_stage u_stage (
      .clk                     (clk),
      .reset_n                 (reset_n),
      .cfg                     (cfg),
      .stage_enable            (stage_enable),
      .can_write               (can_write),
      .can_read                (can_read),
      .read_compare_fifo_empty (fifo_empty),
      .addr_gen_select         (addr_gen_select),
      .do_write                (do_write),
      .do_read                 (do_read),
      .block_start             (block_start),
      .read_start              (read_start),
      .stage_complete          (stage_complete)
   );

   tg_addr_gen u_addr_gen (
      .clk             (clk),
      .reset_n         (reset_n),
      .addr_gen_select (addr_gen_select),
      .block_start     (block_start),
      .read_start      (read_start),
      .advance         (do_write || do_read),
      .addr            (addr)
   );

   tg_cmd_issue u_cmd_issue (
      .clk       (clk),
      .reset_n   (reset_n),
      .do_write  (do_write),
      .do_read   (do_read),
      .addr      (addr),
      .mem_ready (mem_ready),
      .cmd       (cmd)
   );

   // Error state clears with each start request
   tg_read_compare u_read_compare (
      .clk              (clk),
      .reset_n          (reset_n),
      .clear            (stage_enable),
      .push             (do_read),
      .push_addr        (addr),
      .rsp              (rsp),
      .fifo_full        (fifo_full),
      .fifo_empty       (fifo_empty),
      .error_count      (error_count),
      .first_error_addr (first_error_addr),
      .mismatch_seen    (mismatch_seen)
   );

   assign status = '{
      complete:         stage_complete,
      error_count:      error_count,
      first_error_addr: first_error_addr.flat,
      mismatch_seen:    mismatch_seen
   };

endmodule

`default_nettype wire

/* rtl/tg_read_compare.sv */
//////////////////////////////////////////////////
// Read data checker of the traffic generator
// Queues read addresses, pops one per response and
// checks the data against the write pattern
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tg_read_compare (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  clear,
   input  logic                  push,
   input  tg_mem_pkg::mem_addr_u push_addr,
   input  tg_mem_pkg::mem_rsp_t  rsp,
   output logic                  fifo_full,
   output logic                  fifo_empty,
   output logic [15:0]           error_count,
   output tg_mem_pkg::mem_addr_u first_error_addr,
   output logic                  mismatch_seen
);

   tg_mem_pkg::mem_addr_u             fifo_mem [tg_mem_pkg::FIFO_DEPTH];
   logic [tg_mem_pkg::FIFO_PTR_W-1:0] wr_ptr;
   logic [tg_mem_pkg::FIFO_PTR_W-1:0] rd_ptr;
   logic [tg_mem_pkg::FIFO_PTR_W:0]   count;
   tg_mem_pkg::mem_addr_u             exp_addr;
   logic                              mismatch;

   //////////////////////////////////////////////////
   // Expected address FIFO
   //////////////////////////////////////////////////
   assign fifo_full  = (count == (tg_mem_pkg::FIFO_PTR_W + 1)'(tg_mem_pkg::FIFO_DEPTH));
   assign fifo_empty = (count == '0);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (rsp.valid)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, rsp.valid})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
      if (push)
         fifo_mem[wr_ptr] <= push_addr;
   end

   //////////////////////////////////////////////////
   // Data check
   //////////////////////////////////////////////////
   // Head of FIFO is the address of the returning read
   assign exp_addr = fifo_mem[rd_ptr];
   assign mismatch = rsp.valid && (rsp.rdata != tg_cfg_pkg::tg_pattern(exp_addr.flat));

   always_ff @(posedge clk) begin
      if (!reset_n || clear) begin
         error_count      <= '0;
         first_error_addr <= '0;
         mismatch_seen    <= 1'b0;
      end else if (mismatch) begin
         // Saturates rather than wraps
         if (error_count != '1)
            error_count <= error_count + 1'b1;
         if (!mismatch_seen)
            first_error_addr <= exp_addr;
         mismatch_seen <= 1'b1;
      end
   end

   // Memory answers only reads that were issued
   a_rsp_has_entry : assert property (@(posedge clk) disable iff (!reset_n)
      rsp.valid |-> !fifo_empty);

endmodule

`default_nettype wire

/* rtl/tg_cmd_issue.sv */
//////////////////////////////////////////////////
// Command register toward the memory
// Adds the pattern data to writes, one cycle after
// the stage asks for a command
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tg_cmd_issue (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  do_write,
   input  logic                  do_read,
   input  tg_mem_pkg::mem_addr_u addr,
   input  logic                  mem_ready,
   output tg_mem_pkg::mem_cmd_t  cmd
);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         cmd.write <= 1'b0;
         cmd.read  <= 1'b0;
      end else begin
         cmd.write <= do_write;
         cmd.read  <= do_read;
      end
      cmd.addr <= addr;
      // Read commands carry no data
      cmd.wdata <= do_write ? tg_cfg_pkg::tg_pattern(addr.flat) : '0;
   end

   // Stage only issues while the memory is ready
   a_ready_before_cmd : assert property (@(posedge clk) disable iff (!reset_n)
      (cmd.write || cmd.read) |-> $past(mem_ready));

endmodule

`default_nettype wire

/* rtl/tg_addr_gen.sv */
//////////////////////////////////////////////////
// Address generators of the traffic generator
// Saves its state at each block start and replays
// it at read start so reads follow the writes
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tg_addr_gen (
   input  logic                         clk,
   input  logic                         reset_n,
   input  tg_cfg_pkg::addr_gen_select_t addr_gen_select,
   input  logic                         block_start,
   input  logic                         read_start,
   input  logic                         advance,
   output tg_mem_pkg::mem_addr_u        addr
);

   // State of all three generators
   typedef struct packed {
      logic [tg_cfg_pkg::ADDR_W-1:0] seq_cnt;
      logic [tg_cfg_pkg::ADDR_W-1:0] lfsr;
      logic [tg_mem_pkg::BANK_W-1:0] rs_bank;
      logic [tg_mem_pkg::ROW_W-1:0]  rs_row;
      logic [tg_mem_pkg::COL_W-1:0]  rs_col;
   } gen_state_t;

   gen_state_t cur;
   gen_state_t nxt;
   gen_state_t saved;

   // Galois LFSR, taps 16,14,13,11
   function automatic logic [tg_cfg_pkg::ADDR_W-1:0] lfsr_step(
      input logic [tg_cfg_pkg::ADDR_W-1:0] v);
      return (v >> 1) ^ (v[0] ? 16'hB400 : 16'h0000);
   endfunction

   always_comb begin
      nxt = cur;
      if (advance) begin
         case (addr_gen_select)
            tg_cfg_pkg::SEQ:      nxt.seq_cnt = cur.seq_cnt + 1'b1;
            tg_cfg_pkg::RAND:     nxt.lfsr    = lfsr_step(cur.lfsr);
            tg_cfg_pkg::RAND_SEQ: nxt.rs_col  = cur.rs_col + 1'b1;
            default:              nxt = cur;
         endcase
      end
      // New bank and row each block, column restarts at 0
      if (block_start) begin
         nxt.rs_bank = nxt.lfsr[tg_cfg_pkg::ADDR_W-1 -: tg_mem_pkg::BANK_W];
         nxt.rs_row  = nxt.lfsr[tg_mem_pkg::ROW_W-1:0];
         nxt.rs_col  = '0;
         nxt.lfsr    = lfsr_step(nxt.lfsr);
      end
      // Replay overrides the last write advance
      if (read_start)
         nxt = saved;
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         cur.seq_cnt <= '0;
         cur.lfsr    <= 16'hACE1;
         cur.rs_bank <= '0;
         cur.rs_row  <= '0;
         cur.rs_col  <= '0;
      end else begin
         cur <= nxt;
      end
      if (block_start)
         saved <= nxt;
   end

   // Present the selected generator
   always_comb begin
      addr.flat = cur.seq_cnt;
      case (addr_gen_select)
         tg_cfg_pkg::RAND:
            addr.flat = cur.lfsr;
         tg_cfg_pkg::RAND_SEQ: begin
            addr.f.bank = cur.rs_bank;
            addr.f.row  = cur.rs_row;
            addr.f.col  = cur.rs_col;
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/tg_block_rw_stage.sv */
//////////////////////////////////////////////////
// Block write/read stage of the traffic generator
// Writes block_size words, reads them back, and
// steps through SEQ, RAND and RAND_SEQ blocks
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tg_block_rw_stage (
   input  logic                         clk,
   input  logic                         reset_n,
   input  tg_cfg_pkg::tg_cfg_t          cfg,
   input  logic                         stage_enable,
   input  logic                         can_write,
   input  logic                         can_read,
   input  logic                         read_compare_fifo_empty,
   output tg_cfg_pkg::addr_gen_select_t addr_gen_select,
   output logic                         do_write,
   output logic                         do_read,
   output logic                         block_start,
   output logic                         read_start,
   output logic                         stage_complete
);

   typedef logic [tg_cfg_pkg::BLK_W-1:0] blk_t;

   typedef enum logic [2:0] {
      INIT,
      BLOCK_WRITE,
      BLOCK_READ,
      WAIT_ADDR_GEN,
      WAIT,
      DONE
   } state_t;

   state_t                         state;
   state_t                         state_nxt;
   tg_cfg_pkg::tg_cfg_t            cfg_r;
   tg_cfg_pkg::tg_cfg_t            cfg_use;
   blk_t                           block_idx;
   blk_t                           total;
   logic [tg_cfg_pkg::CNT_W-1:0]   size_cnt;
   logic                           last_op;
   logic                           cfg_empty;
   tg_cfg_pkg::addr_gen_select_t   sel_next;

   // Generator for block number idx
   function automatic tg_cfg_pkg::addr_gen_select_t sel_for(input blk_t idx,
                                                            input tg_cfg_pkg::tg_cfg_t c);
      blk_t seq_end;
      blk_t rand_end;
      seq_end  = blk_t'(c.seq_count);
      rand_end = seq_end + blk_t'(c.rand_count);
      if (idx < seq_end)
         return tg_cfg_pkg::SEQ;
      else if (idx < rand_end)
         return tg_cfg_pkg::RAND;
      return tg_cfg_pkg::RAND_SEQ;
   endfunction

   // Live cfg while idle, latched copy once running
   assign cfg_use   = (state == INIT) ? cfg : cfg_r;
   assign total     = blk_t'(cfg_use.seq_count) + blk_t'(cfg_use.rand_count) +
                      blk_t'(cfg_use.rand_seq_count);
   assign cfg_empty = (total == '0) || (cfg_use.block_size == '0);
   assign sel_next  = sel_for(block_idx, cfg_use);
   assign last_op   = (size_cnt == cfg_r.block_size - 1'b1);

   //////////////////////////////////////////////////
   // Next state
   //////////////////////////////////////////////////
   always_comb begin
      state_nxt = state;
      case (state)
         INIT:
            if (stage_enable)
               state_nxt = cfg_empty ? DONE : BLOCK_WRITE;
         BLOCK_WRITE:
            if (can_write && last_op)
               state_nxt = BLOCK_READ;
         BLOCK_READ:
            if (can_read && last_op) begin
               if (block_idx == total)
                  state_nxt = WAIT;
               // Generator changes only after all reads are back
               else if (sel_next != addr_gen_select)
                  state_nxt = WAIT_ADDR_GEN;
               else
                  state_nxt = BLOCK_WRITE;
            end
         WAIT_ADDR_GEN:
            if (read_compare_fifo_empty)
               state_nxt = BLOCK_WRITE;
         WAIT:
            if (read_compare_fifo_empty)
               state_nxt = DONE;
         DONE:
            state_nxt = INIT;
         default:
            state_nxt = INIT;
      endcase
   end

   // Pulses in the cycle that moves the FSM into a block phase
   assign block_start = (state_nxt == BLOCK_WRITE) && (state != BLOCK_WRITE);
   assign read_start  = (state_nxt == BLOCK_READ) && (state != BLOCK_READ);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state           <= INIT;
         cfg_r           <= '0;
         block_idx       <= '0;
         size_cnt        <= '0;
         addr_gen_select <= tg_cfg_pkg::SEQ;
      end else begin
         state <= state_nxt;
         if (state == INIT && stage_enable)
            cfg_r <= cfg;
         // Select and count the block being started
         if (block_start) begin
            block_idx       <= block_idx + 1'b1;
            addr_gen_select <= sel_next;
         end
         if (do_write || do_read)
            size_cnt <= last_op ? '0 : size_cnt + 1'b1;
         if (state == DONE)
            block_idx <= '0;
      end
   end

   //////////////////////////////////////////////////
   // Command and status outputs
   //////////////////////////////////////////////////
   assign do_write       = (state == BLOCK_WRITE) && can_write;
   assign do_read        = (state == BLOCK_READ) && can_read;
   assign stage_complete = (state == DONE);

   // One command kind per cycle toward the issuer
   a_one_cmd : assert property (@(posedge clk) disable iff (!reset_n)
      !(do_write && do_read));

endmodule

`default_nettype wire

/* rtl/tg_mem_pkg.sv */
//////////////////////////////////////////////////
// Memory side types of the traffic generator
// Command and read return words, and the address
// seen either flat or as bank, row and column
//////////////////////////////////////////////////
`default_nettype none

package tg_mem_pkg;

   // Expected address FIFO in the read checker
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

   // Address split, sums to ADDR_W
   localparam int BANK_W = 2;
   localparam int ROW_W  = 8;
   localparam int COL_W  = 6;

   typedef struct packed {
      logic [BANK_W-1:0] bank;
      logic [ROW_W-1:0]  row;
      logic [COL_W-1:0]  col;
   } mem_addr_fields_t;

   typedef union packed {
      logic [tg_cfg_pkg::ADDR_W-1:0] flat;
      mem_addr_fields_t              f;
   } mem_addr_u;

   // One command per cycle, at most one of write and read set
   typedef struct packed {
      logic                          write;
      logic                          read;
      mem_addr_u                     addr;
      logic [tg_cfg_pkg::DATA_W-1:0] wdata;
   } mem_cmd_t;

   // Read data come back in order
   typedef struct packed {
      logic                          valid;
      logic [tg_cfg_pkg::DATA_W-1:0] rdata;
   } mem_rsp_t;

endpackage

`default_nettype wire

/* rtl/tg_cfg_pkg.sv */
//////////////////////////////////////////////////
// Test control types for the traffic generator
// Holds the runtime configuration, the status word
// and the data pattern shared by writer and checker
//////////////////////////////////////////////////
`default_nettype none

package tg_cfg_pkg;

   // Bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // Block counts and block size
   localparam int CNT_W  = 8;
   // Wide enough for the sum of all three block counts
   localparam int BLK_W  = CNT_W + 2;

   typedef enum logic [1:0] {
      SEQ,
      RAND,
      RAND_SEQ
   } addr_gen_select_t;

   // Sampled by the stage when it leaves INIT
   typedef struct packed {
      logic [CNT_W-1:0] seq_count;
      logic [CNT_W-1:0] rand_count;
      logic [CNT_W-1:0] rand_seq_count;
      logic [CNT_W-1:0] block_size;
   } tg_cfg_t;

   typedef struct packed {
      logic              complete;
      logic [15:0]       error_count;
      logic [ADDR_W-1:0] first_error_addr;
      logic              mismatch_seen;
   } tg_status_t;

   // Address in the high half, scrambled address in the low half
   function automatic logic [DATA_W-1:0] tg_pattern(input logic [ADDR_W-1:0] addr);
      return {addr, addr ^ 16'hA5C3};
   endfunction

endpackage

`default_nettype wire
